//--- Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
SIM_ARGS  ?=

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- common/cache_pkg.sv
`default_nettype none
`include "icache_config.svh"

package cache_pkg;

	typedef struct packed {
		logic [`ICACHE_TAG_BITS-1:0]         tag;
		logic [`ICACHE_INDEX_BITS-1:0]       index;
		logic [`ICACHE_WORD_OFFSET_BITS-1:0] word_off;
		logic [`ICACHE_BYTE_OFFSET_BITS-1:0] byte_off;
	} addr_fields_t;

	// raw view for the bus, field view for the rams
	typedef union packed {
		logic [31:0]  raw;
		addr_fields_t fields;
	} fetch_addr_u;

	typedef struct packed {
		logic                        valid;
		logic [`ICACHE_TAG_BITS-1:0] tag;
	} tag_entry_t;

	typedef logic [`ICACHE_LINE_BITS/`ICACHE_WORD_BITS-1:0][`ICACHE_WORD_BITS-1:0] line_t;

	typedef enum logic [2:0] {
		idle,
		wait_ready,
		receiving,
		finish,
		flush_wait_ready,
		flush_receiving
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- common/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache geometry
`define ICACHE_LINE_BITS 256
`define ICACHE_WORD_BITS 64
`define ICACHE_WAYS 4
`define ICACHE_SETS 16

// refill bus beat width
`define ICACHE_BEAT_BITS 32

// fetch address split, msb to lsb
`define ICACHE_TAG_BITS 23
`define ICACHE_INDEX_BITS 4
`define ICACHE_WORD_OFFSET_BITS 2
`define ICACHE_BYTE_OFFSET_BITS 3

`endif

//--- common/mem_bus_pkg.sv
`default_nettype none
`include "icache_config.svh"

package mem_bus_pkg;

	typedef logic [`ICACHE_BEAT_BITS-1:0] beat_t;

	// beats per line minus one
	localparam logic [7:0] BURST_LEN = 8'(`ICACHE_LINE_BITS / `ICACHE_BEAT_BITS - 1);

	// log2 of bytes per beat
	localparam logic [2:0] BURST_SIZE = 3'd2;

endpackage

`default_nettype wire

//--- compile.f
+incdir+common
common/cache_pkg.sv
common/mem_bus_pkg.sv
design/single_port_ram.sv
design/lfsr_8bits.sv
icache/line_fill_buffer.sv
icache/icache_ways.sv
icache/icache_ctrl.sv
icache/icache.sv
tb/burst_mem_model.sv
tb/icache_assertions.sv
tb/icache_tb.sv

//--- design/lfsr_8bits.sv
`default_nettype none

module lfsr_8bits (
	input  wire        clk,
	input  wire        rst,
	input  wire        update,
	output logic [7:0] val
);

	// galois form of x^8 + x^6 + x^5 + x^4 + 1
	always_ff @(posedge clk) begin
		if (rst)
			val <= 8'h5a;
		else if (update)
			val <= {1'b0, val[7:1]} ^ (val[0] ? 8'hb8 : 8'h00);
	end

endmodule

`default_nettype wire

//--- design/single_port_ram.sv
`default_nettype none

module single_port_ram #(
	parameter int depth = 16,
	parameter int width = 32
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     we,
	input  wire [$clog2(depth)-1:0] addr,
	input  wire [width-1:0]         din,
	output logic [width-1:0]        dout
);

	logic [width-1:0] mem [depth];

	// write-first, so a refilled set reads back on the next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
			dout <= '0;
		end else if (we) begin
			mem[addr] <= din;
			dout      <= din;
		end else begin
			dout <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- icache/icache.sv
`default_nettype none
`include "icache_config.svh"

module icache (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          fetch_read,
	input  wire [31:0]                   fetch_addr,
	input  wire                          flush_1,
	input  wire                          flush_2,
	output logic                         stall,
	output logic                         valid,
	output logic                         extra_valid,
	output logic [`ICACHE_WORD_BITS-1:0] rddata,
	output logic [`ICACHE_WORD_BITS-1:0] rddata_extra,
	output logic                         arvalid,
	output logic [31:0]                  araddr,
	output logic [7:0]                   arlen,
	input  wire                          arready,
	input  wire                          rvalid,
	input  wire [`ICACHE_BEAT_BITS-1:0]  rdata,
	input  wire                          rlast,
	output logic                         rready
);

	logic [`ICACHE_WAYS-1:0]       hit;
	logic [`ICACHE_WAYS-1:0]       way_we;
	logic [`ICACHE_INDEX_BITS-1:0] ram_index;
	cache_pkg::fetch_addr_u        stage2_addr;
	logic                          stage2_valid;
	logic                          beat_capture;
	logic [2:0]                    beat_index;
	logic                          lfsr_update;
	logic [7:0]                    lfsr_val;
	cache_pkg::line_t              fill_line;

	icache_ctrl ctrl (
		.clk,
		.rst,
		.fetch_read,
		.fetch_addr,
		.flush_1,
		.flush_2,
		.hit,
		.arready,
		.rvalid,
		.rlast,
		.lfsr_val,
		.stall,
		.ram_index,
		.stage2_addr,
		.stage2_valid,
		.way_we,
		.beat_capture,
		.beat_index,
		.lfsr_update,
		.arvalid,
		.araddr,
		.arlen,
		.rready
	);

	icache_ways ways (
		.clk,
		.rst,
		.ram_index,
		.stage2_addr,
		.stage2_valid,
		.flush_2,
		.stall,
		.way_we,
		.fill_line,
		.hit,
		.valid,
		.extra_valid,
		.rddata,
		.rddata_extra
	);

	line_fill_buffer fill_buf (
		.clk,
		.rst,
		.beat_capture,
		.beat_index,
		.rdata,
		.fill_line
	);

	lfsr_8bits lfsr (
		.clk,
		.rst,
		.update ( lfsr_update ),
		.val    ( lfsr_val    )
	);

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
`default_nettype none
`include "icache_config.svh"

module icache_ctrl (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           fetch_read,
	input  wire cache_pkg::fetch_addr_u   fetch_addr,
	input  wire                           flush_1,
	input  wire                           flush_2,
	input  wire [`ICACHE_WAYS-1:0]        hit,
	input  wire                           arready,
	input  wire                           rvalid,
	input  wire                           rlast,
	input  wire [7:0]                     lfsr_val,
	output logic                          stall,
	output logic [`ICACHE_INDEX_BITS-1:0] ram_index,
	output cache_pkg::fetch_addr_u        stage2_addr,
	output logic                          stage2_valid,
	output logic [`ICACHE_WAYS-1:0]       way_we,
	output logic                          beat_capture,
	output logic [2:0]                    beat_index,
	output logic                          lfsr_update,
	output logic                          arvalid,
	output logic [31:0]                   araddr,
	output logic [7:0]                    arlen,
	output logic                          rready
);

	localparam int way_bits = $clog2(`ICACHE_WAYS);
	localparam int line_off_bits = `ICACHE_WORD_OFFSET_BITS + `ICACHE_BYTE_OFFSET_BITS;

	cache_pkg::ctrl_state_t state;
	cache_pkg::ctrl_state_t state_d;
	logic                   miss;
	logic                   last_beat;
	logic                   fill_we;
	logic [31:0]            refill_addr;

	assign miss      = stage2_valid & ~(|hit);
	assign last_beat = rvalid & rlast;

	always_comb begin
		state_d = state;
		case (state)
			cache_pkg::idle, cache_pkg::finish: begin
				if (miss & ~flush_2)
					state_d = cache_pkg::wait_ready;
				else
					state_d = cache_pkg::idle;
			end
			cache_pkg::wait_ready: begin
				if (arready)
					state_d = flush_2 ? cache_pkg::flush_receiving : cache_pkg::receiving;
				else if (flush_2)
					state_d = cache_pkg::flush_wait_ready;
			end
			cache_pkg::flush_wait_ready: begin
				if (arready)
					state_d = cache_pkg::flush_receiving;
			end
			cache_pkg::receiving, cache_pkg::flush_receiving: begin
				if (last_beat)
					state_d = cache_pkg::finish;
				else if (flush_2)
					state_d = cache_pkg::flush_receiving;
			end
			default: state_d = cache_pkg::idle;
		endcase
	end

	// a cancelled fetch releases stage 2 while the burst drains
	assign stall = (state_d != cache_pkg::idle) & stage2_valid & ~flush_2;

	// replay lookup reads the refilled set
	assign ram_index = (state_d == cache_pkg::finish && stage2_valid) ?
		stage2_addr.fields.index : fetch_addr.fields.index;

	assign arvalid = (state == cache_pkg::wait_ready) || (state == cache_pkg::flush_wait_ready);
	assign rready  = (state == cache_pkg::receiving) || (state == cache_pkg::flush_receiving);
	assign araddr  = refill_addr;
	assign arlen   = mem_bus_pkg::BURST_LEN;

	assign beat_capture = (state == cache_pkg::receiving) & rvalid;
	assign fill_we      = (state == cache_pkg::receiving) & last_beat & ~flush_2;
	assign lfsr_update  = fill_we;

	always_comb begin
		for (int i = 0; i < `ICACHE_WAYS; i++)
			way_we[i] = fill_we && (lfsr_val[way_bits-1:0] == i);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= cache_pkg::idle;
			beat_index <= '0;
		end else begin
			state <= state_d;
			if (arvalid)
				beat_index <= '0;
			else if (rready & rvalid)
				beat_index <= beat_index + 3'd1;
		end
	end

	// line address frozen once the request is out
	always_ff @(posedge clk) begin
		if (state == cache_pkg::idle || state == cache_pkg::finish)
			refill_addr <= {stage2_addr.raw[31:line_off_bits], {line_off_bits{1'b0}}};
	end

	always_ff @(posedge clk) begin
		if (rst)
			stage2_valid <= 1'b0;
		else if (~stall)
			stage2_valid <= fetch_read & ~flush_1;
	end

	always_ff @(posedge clk) begin
		if (~stall)
			stage2_addr <= fetch_addr;
	end

endmodule

`default_nettype wire

//--- icache/icache_ways.sv
`default_nettype none
`include "icache_config.svh"

module icache_ways (
	input  wire                           clk,
	input  wire                           rst,
	input  wire [`ICACHE_INDEX_BITS-1:0]  ram_index,
	input  wire cache_pkg::fetch_addr_u   stage2_addr,
	input  wire                           stage2_valid,
	input  wire                           flush_2,
	input  wire                           stall,
	input  wire [`ICACHE_WAYS-1:0]        way_we,
	input  wire cache_pkg::line_t         fill_line,
	output logic [`ICACHE_WAYS-1:0]       hit,
	output logic                          valid,
	output logic                          extra_valid,
	output logic [`ICACHE_WORD_BITS-1:0]  rddata,
	output logic [`ICACHE_WORD_BITS-1:0]  rddata_extra
);

	cache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]           tag_rd;
	cache_pkg::tag_entry_t                              tag_wr;
	cache_pkg::line_t [`ICACHE_WAYS-1:0]                data_rd;
	logic [`ICACHE_WORD_OFFSET_BITS-1:0]                word_off;
	logic [`ICACHE_WORD_OFFSET_BITS-1:0]                next_off;
	logic [`ICACHE_WAYS-1:0]                            hit_q;
	logic [`ICACHE_WAYS-1:0][`ICACHE_WORD_BITS-1:0]     word_q;
	logic [`ICACHE_WAYS-1:0][`ICACHE_WORD_BITS-1:0]     extra_q;

	assign tag_wr.valid = 1'b1;
	assign tag_wr.tag   = stage2_addr.fields.tag;
	assign word_off     = stage2_addr.fields.word_off;
	assign next_off     = word_off + 1'b1;

	for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : g_way
		single_port_ram #(
			.depth ( `ICACHE_SETS                   ),
			.width ( $bits(cache_pkg::tag_entry_t) )
		) tag_ram (
			.clk,
			.rst,
			.we   ( way_we[i] ),
			.addr ( ram_index ),
			.din  ( tag_wr    ),
			.dout ( tag_rd[i] )
		);

		single_port_ram #(
			.depth ( `ICACHE_SETS      ),
			.width ( `ICACHE_LINE_BITS )
		) data_ram (
			.clk,
			.rst,
			.we   ( way_we[i]  ),
			.addr ( ram_index  ),
			.din  ( fill_line  ),
			.dout ( data_rd[i] )
		);

		assign hit[i] = tag_rd[i].valid && (tag_rd[i].tag == stage2_addr.fields.tag);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q       <= '0;
			valid       <= 1'b0;
			extra_valid <= 1'b0;
		end else begin
			hit_q       <= hit;
			valid       <= stage2_valid & ~stall & ~flush_2;
			// no next word past the end of the line
			extra_valid <= stage2_valid & ~stall & ~flush_2 & ~(&word_off);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `ICACHE_WAYS; i++) begin
			word_q[i]  <= data_rd[i][word_off];
			extra_q[i] <= data_rd[i][next_off];
		end
	end

	always_comb begin
		rddata       = '0;
		rddata_extra = '0;
		for (int i = 0; i < `ICACHE_WAYS; i++) begin
			rddata       |= {`ICACHE_WORD_BITS{hit_q[i]}} & word_q[i];
			rddata_extra |= {`ICACHE_WORD_BITS{hit_q[i]}} & extra_q[i];
		end
	end

endmodule

`default_nettype wire

//--- icache/line_fill_buffer.sv
`default_nettype none
`include "icache_config.svh"

module line_fill_buffer (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     beat_capture,
	input  wire [2:0]               beat_index,
	input  wire mem_bus_pkg::beat_t rdata,
	output cache_pkg::line_t        fill_line
);

	localparam int beats = `ICACHE_LINE_BITS / (8 << mem_bus_pkg::BURST_SIZE);

	mem_bus_pkg::beat_t [beats-2:0] beat_q;

	always_ff @(posedge clk) begin
		if (rst)
			beat_q <= '0;
		else if (beat_capture && beat_index != 3'(beats - 1))
			beat_q[beat_index] <= rdata;
	end

	// last beat goes straight from the bus into the top word
	assign fill_line = {rdata, beat_q};

endmodule

`default_nettype wire

//--- tb/burst_mem_model.sv
`default_nettype none

module burst_mem_model #(
	parameter logic [31:0] data_key = 32'h0
) (
	input  wire         clk,
	input  wire         rst,
	input  wire         arvalid,
	input  wire  [31:0] araddr,
	input  wire  [7:0]  arlen,
	output logic        arready,
	output logic        rvalid,
	output logic [31:0] rdata,
	output logic        rlast,
	input  wire         rready
);
	timeunit 1ns;
	timeprecision 1ps;

	integer      seed = 60649;
	logic        rst_s;
	logic        ar_fire;
	logic        r_fire;
	logic [31:0] ar_addr_s;
	logic [7:0]  ar_len_s;
	logic        busy;
	logic [31:0] base;
	logic [7:0]  len;
	logic [7:0]  beat;

	initial begin
		arready = 1'b0;
		rvalid  = 1'b0;
		rdata   = '0;
		rlast   = 1'b0;
		busy    = 1'b0;
		base    = '0;
		len     = '0;
		beat    = '0;
		rst_s   = 1'b1;
		ar_fire = 1'b0;
		r_fire  = 1'b0;
	end

	// handshakes seen mid-cycle, where everything has settled
	always @(negedge clk) begin
		rst_s     = rst;
		ar_fire   = arvalid && arready;
		r_fire    = rvalid && rready;
		ar_addr_s = araddr;
		ar_len_s  = arlen;
	end

	always @(posedge clk) begin
		#2;
		if (rst_s) begin
			arready = 1'b0;
			rvalid  = 1'b0;
			rlast   = 1'b0;
			busy    = 1'b0;
		end else begin
			if (ar_fire) begin
				busy = 1'b1;
				base = ar_addr_s;
				len  = ar_len_s;
				beat = 8'd0;
			end else if (r_fire) begin
				if (beat == len)
					busy = 1'b0;
				beat = beat + 8'd1;
			end
			arready = !busy && (($random(seed) & 3) != 0);
			// a beat on offer stays until it is taken
			if (!(rvalid && !r_fire))
				rvalid = busy && (($random(seed) & 3) != 0);
			rdata = (base + {22'b0, beat, 2'b00}) ^ data_key;
			rlast = (beat == len);
		end
	end

endmodule

`default_nettype wire

//--- tb/icache_assertions.sv
`default_nettype none
`include "icache_config.svh"

module icache_assertions (
	input wire                         clk,
	input wire                         rst,
	input wire                         arvalid,
	input wire                         arready,
	input wire [31:0]                  araddr,
	input wire                         stall,
	input wire                         rvalid,
	input wire                         rlast,
	input wire                         rready,
	input wire [`ICACHE_WAYS-1:0]      way_we,
	input wire cache_pkg::ctrl_state_t state
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	property request_holds;
		@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr);
	endproperty

	// replay after a refill must hit the line just written
	property no_finish_stall;
		@(posedge clk) disable iff (rst)
		(state == cache_pkg::finish) |-> !stall;
	endproperty

	// a line is written only on the beat that carries rlast
	property single_way_write;
		@(posedge clk) disable iff (rst)
		$onehot0(way_we) && (!(|way_we) || (rvalid && rlast && rready));
	endproperty

	assert property (request_holds) else begin
		fail_count++;
		$error("arvalid or araddr changed before arready");
	end

	assert property (no_finish_stall) else begin
		fail_count++;
		$error("stall still high after the refilled line was written");
	end

	assert property (single_way_write) else begin
		fail_count++;
		$error("way write enable not one-hot or not on the last beat");
	end

endmodule

bind icache_ctrl icache_assertions assertions (
	.clk,
	.rst,
	.arvalid,
	.arready,
	.araddr,
	.stall,
	.rvalid,
	.rlast,
	.rready,
	.way_we,
	.state
);

`default_nettype wire

//--- tb/icache_tb.sv
`default_nettype none
`include "icache_config.svh"

module icache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] data_key = 32'h5ca1_ab1e;
	localparam int num_entries = 25;
	localparam int cycle_limit = num_entries * 60;

	// flush 0 none, 1 in stage 1, 2 during the refill
	// group 1 fills five lines of set 3, group 2 refetches them
	typedef struct packed {
		logic [31:0] addr;
		logic [1:0]  flush;
		logic [1:0]  group;
	} entry_t;

	localparam entry_t stim [num_entries] = '{
		'{32'h0000_1000, 2'd0, 2'd0},
		'{32'h0000_1000, 2'd0, 2'd0},
		'{32'h0000_1008, 2'd0, 2'd0},
		'{32'h0000_1010, 2'd0, 2'd0},
		'{32'h0000_1018, 2'd0, 2'd0},
		'{32'h0000_2344, 2'd0, 2'd0},
		'{32'h0000_2060, 2'd0, 2'd1},
		'{32'h0000_2268, 2'd0, 2'd1},
		'{32'h0000_2470, 2'd0, 2'd1},
		'{32'h0000_2678, 2'd0, 2'd1},
		'{32'h0000_2860, 2'd0, 2'd1},
		'{32'h0000_2078, 2'd0, 2'd2},
		'{32'h0000_2260, 2'd0, 2'd2},
		'{32'h0000_2468, 2'd0, 2'd2},
		'{32'h0000_2670, 2'd0, 2'd2},
		'{32'h0000_2868, 2'd0, 2'd2},
		'{32'h0000_4000, 2'd1, 2'd0},
		'{32'h0000_4000, 2'd0, 2'd0},
		'{32'h0000_5020, 2'd2, 2'd0},
		'{32'h0000_5020, 2'd0, 2'd0},
		'{32'h0000_5028, 2'd0, 2'd0},
		'{32'h0001_f0e8, 2'd0, 2'd0},
		'{32'h8000_0010, 2'd0, 2'd0},
		'{32'hffff_fff8, 2'd0, 2'd0},
		'{32'hffff_fff8, 2'd0, 2'd0}
	};

	logic                         clk = 1'b0;
	logic                         rst;
	logic                         fetch_read;
	logic [31:0]                  fetch_addr;
	logic                         flush_1;
	logic                         flush_2;
	logic                         stall;
	logic                         valid;
	logic                         extra_valid;
	logic [`ICACHE_WORD_BITS-1:0] rddata;
	logic [`ICACHE_WORD_BITS-1:0] rddata_extra;
	logic                         arvalid;
	logic [31:0]                  araddr;
	logic [7:0]                   arlen;
	logic                         arready;
	logic                         rvalid;
	logic [31:0]                  rdata;
	logic                         rlast;
	logic                         rready;

	// reference model, lines known to be in the cache
	logic [31:0] last_fill [16];
	logic        last_fill_ok [16];
	logic        ever_filled [logic [31:0]];

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          req_count = 0;
	int          group_misses = 0;
	logic [31:0] last_araddr = '0;

	icache dut (
		.clk,
		.rst,
		.fetch_read,
		.fetch_addr,
		.flush_1,
		.flush_2,
		.stall,
		.valid,
		.extra_valid,
		.rddata,
		.rddata_extra,
		.arvalid,
		.araddr,
		.arlen,
		.arready,
		.rvalid,
		.rdata,
		.rlast,
		.rready
	);

	burst_mem_model #(
		.data_key ( data_key )
	) burst_mem_model (
		.clk,
		.rst,
		.arvalid,
		.araddr,
		.arlen,
		.arready,
		.rvalid,
		.rdata,
		.rlast,
		.rready
	);

	always #10 clk = ~clk;

	// word w of a line is beats 2w and 2w+1, low beat in the low half
	function automatic logic [63:0] line_word(input logic [31:0] base, input logic [1:0] w);
		logic [31:0] lo_addr;
		lo_addr = base + {27'b0, w, 3'b000};
		return {(lo_addr + 32'd4) ^ data_key, lo_addr ^ data_key};
	endfunction

	task automatic check_word(input string label, input logic [31:0] addr,
			input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s for %h is %h, expected %h", $time, label, addr, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic finish_run();
		errors = errors + dut.ctrl.assertions.fail_count;
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	// flush_2 after a non-final beat, then the burst drains unwritten
	task automatic cancel_refill(input logic [31:0] addr);
		do
			@(negedge clk);
		while (!(rready && rvalid && !rlast));
		@(posedge clk);
		#2;
		flush_2 = 1'b1;
		@(posedge clk);
		#2;
		flush_2 = 1'b0;
		do begin
			@(negedge clk);
			checks++;
			if (valid)
				report_error($sformatf("cancelled refill of %h still returned valid", addr));
		end while (rready || arvalid);
		@(negedge clk);
		checks++;
		if (valid)
			report_error($sformatf("cancelled refill of %h returned valid at the end", addr));
	endtask

	task automatic run_fetch(input logic [31:0] addr, input logic [1:0] flush_kind,
			input logic [1:0] group);
		logic [31:0] base;
		logic [1:0]  w;
		logic [3:0]  set;
		logic        must_hit;
		logic        must_miss;
		logic        missed;
		int          req_before;
		base       = {addr[31:5], 5'b0};
		w          = addr[4:3];
		set        = addr[8:5];
		must_hit   = last_fill_ok[set] && last_fill[set] == base;
		must_miss  = !ever_filled.exists(base);
		req_before = req_count;
		@(posedge clk);
		#2;
		fetch_read = 1'b1;
		fetch_addr = addr;
		flush_1    = (flush_kind == 2'd1);
		do
			@(negedge clk);
		while (stall);
		@(posedge clk);
		#2;
		fetch_read = 1'b0;
		flush_1    = 1'b0;
		if (flush_kind == 2'd1) begin
			@(negedge clk);
			@(negedge clk);
			checks++;
			if (valid || stall || req_count != req_before)
				report_error($sformatf("fetch of %h flushed in stage 1 got a response", addr));
		end else begin
			@(negedge clk);
			missed = stall;
			checks++;
			if (must_hit && missed)
				report_error($sformatf("fetch of %h missed on a resident line", addr));
			if (must_miss && !missed)
				report_error($sformatf("fetch of %h hit on a line never filled", addr));
			if (group == 2'd2 && missed)
				group_misses++;
			if (flush_kind == 2'd2 && missed) begin
				cancel_refill(addr);
			end else begin
				do
					@(negedge clk);
				while (!valid);
				check_word("rddata", addr, rddata, line_word(base, w));
				check_word("extra_valid", addr, {63'b0, extra_valid}, {63'b0, w != 2'd3});
				if (w != 2'd3)
					check_word("rddata_extra", addr, rddata_extra, line_word(base, w + 2'd1));
				checks++;
				if (missed) begin
					if (req_count != req_before + 1)
						report_error($sformatf("miss on %h did not send one request", addr));
					check_word("araddr", addr, {32'b0, last_araddr}, {32'b0, base});
					last_fill[set]    = base;
					last_fill_ok[set] = 1'b1;
					ever_filled[base] = 1'b1;
				end else if (req_count != req_before) begin
					report_error($sformatf("hit on %h sent a burst request", addr));
				end
			end
		end
	endtask

	always @(negedge clk) begin
		if (!rst && arvalid && arready) begin
			req_count++;
			last_araddr = araddr;
			checks++;
			if (araddr[4:0] != 5'd0 || arlen != 8'd7) begin
				errors++;
				$display("FAIL %0t: request araddr %h arlen %0d, expected aligned with arlen 7",
					$time, araddr, arlen);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout, the run went past %0d cycles", cycle_limit);
			errors++;
			finish_run();
		end
	end

	initial begin
		rst        = 1'b1;
		fetch_read = 1'b0;
		fetch_addr = '0;
		flush_1    = 1'b0;
		flush_2    = 1'b0;
		for (int s = 0; s < 16; s++) begin
			last_fill[s]    = '0;
			last_fill_ok[s] = 1'b0;
		end
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		checks++;
		if (stall || valid || extra_valid || arvalid || rready)
			report_error("outputs not idle after reset");
		for (int i = 0; i < num_entries; i++)
			run_fetch(stim[i].addr, stim[i].flush, stim[i].group);
		checks++;
		if (group_misses < 1)
			report_error("no refetch of the five same-set lines missed");
		finish_run();
	end

endmodule

`default_nettype wire
